//--- ex_pkg.sv
package ex_pkg;

    localparam int XLEN        = 32;
    localparam int REG_AW      = 5;
    localparam int SHAMT_W     = $clog2(XLEN);
    localparam int INSTR_BYTES = 4;

    typedef logic [XLEN-1:0]   data_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        alu_add   = 4'd0,
        alu_sub   = 4'd1,
        alu_sll   = 4'd2,
        alu_slt   = 4'd3,
        alu_sltu  = 4'd4,
        alu_xor   = 4'd5,
        alu_srl   = 4'd6,
        alu_sra   = 4'd7,
        alu_or    = 4'd8,
        alu_and   = 4'd9,
        alu_pass2 = 4'd10  // Passes source 2 through, used by LUI.
    } alu_op_t;

    typedef enum logic [2:0] {
        cmp_beq  = 3'd0,
        cmp_bne  = 3'd1,
        cmp_blt  = 3'd2,
        cmp_bge  = 3'd3,
        cmp_bltu = 3'd4,
        cmp_bgeu = 3'd5
    } cmp_op_t;

    typedef enum logic [1:0] {
        id2ex_buf   = 2'd0,
        mem_forward = 2'd1,
        wb_forward  = 2'd2
    } fwd_sel_t;

    typedef enum logic {
        src1_rs1 = 1'b0,
        src1_pc  = 1'b1
    } src1_sel_t;

    typedef enum logic {
        src2_rs2 = 1'b0,
        src2_imm = 1'b1
    } src2_sel_t;

    typedef struct packed {
        logic      valid;
        data_t     pc;
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        reg_addr_t rd_addr;
        data_t     rs1_data;
        data_t     rs2_data;
        data_t     imm;
        alu_op_t   alu_op;
        src1_sel_t src1_sel;
        src2_sel_t src2_sel;
        cmp_op_t   cmp_op;
        logic      is_branch;
        logic      is_jump;
        logic      wb_en;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd_addr;
        data_t     result;
        logic      wb_en;
        logic      redirect;
        data_t     redirect_pc;
    } ex_mem_t;

endpackage

//--- pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     hold_i,
    input  logic     flush_i,
    input  payload_t d_i,
    output payload_t q_o
);

    payload_t q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            q <= '0;
        end else if (hold_i) begin
            q <= q;
        end else if (flush_i) begin
            q <= '0;  // All-zero payload is a bubble since valid is cleared.
        end else begin
            q <= d_i;
        end
    end

    assign q_o = q;

endmodule

//--- fwd_unit.sv
`timescale 1ns/1ps

module fwd_unit (
    input  ex_pkg::reg_addr_t rs1_addr_i,
    input  ex_pkg::reg_addr_t rs2_addr_i,
    input  ex_pkg::reg_addr_t mem_rd_addr_i,
    input  logic              mem_wr_i,
    input  ex_pkg::reg_addr_t wb_rd_addr_i,
    input  logic              wb_en_i,
    output ex_pkg::fwd_sel_t  rs1_sel_o,
    output ex_pkg::fwd_sel_t  rs2_sel_o
);

    import ex_pkg::*;

    logic mem_live;
    logic wb_live;

    // Register 0 is hardwired, so a write to it never forwards.
    assign mem_live = mem_wr_i && (mem_rd_addr_i != '0);
    assign wb_live  = wb_en_i && (wb_rd_addr_i != '0);

    function automatic fwd_sel_t pick_src(input reg_addr_t src_addr);
        fwd_sel_t sel;
        if (mem_live && (mem_rd_addr_i == src_addr)) begin
            sel = mem_forward;  // The younger result wins.
        end else if (wb_live && (wb_rd_addr_i == src_addr)) begin
            sel = wb_forward;
        end else begin
            sel = id2ex_buf;
        end
        return sel;
    endfunction

    always_comb begin
        rs1_sel_o = pick_src(rs1_addr_i);
        rs2_sel_o = pick_src(rs2_addr_i);
    end

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu (
    input  ex_pkg::alu_op_t alu_op_i,
    input  ex_pkg::data_t   data1_i,
    input  ex_pkg::data_t   data2_i,
    output ex_pkg::data_t   alu_result_o
);

    import ex_pkg::*;

    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;

    assign shamt       = data2_i[SHAMT_W-1:0];
    assign lt_signed   = $signed(data1_i) < $signed(data2_i);
    assign lt_unsigned = data1_i < data2_i;

    always_comb begin
        unique case (alu_op_i)
            alu_add:   alu_result_o = data1_i + data2_i;
            alu_sub:   alu_result_o = data1_i - data2_i;
            alu_sll:   alu_result_o = data1_i << shamt;
            alu_slt:   alu_result_o = data_t'(lt_signed);
            alu_sltu:  alu_result_o = data_t'(lt_unsigned);
            alu_xor:   alu_result_o = data1_i ^ data2_i;
            alu_srl:   alu_result_o = data1_i >> shamt;
            alu_sra:   alu_result_o = data_t'($signed(data1_i) >>> shamt);
            alu_or:    alu_result_o = data1_i | data2_i;
            alu_and:   alu_result_o = data1_i & data2_i;
            alu_pass2: alu_result_o = data2_i;
            default:   alu_result_o = '0;
        endcase
    end

endmodule

//--- branch_cmp.sv
`timescale 1ns/1ps

module branch_cmp (
    input  ex_pkg::cmp_op_t cmp_op_i,
    input  ex_pkg::data_t   data1_i,
    input  ex_pkg::data_t   data2_i,
    output logic            taken_o
);

    import ex_pkg::*;

    logic is_eq;
    logic is_lt;
    logic is_ltu;

    assign is_eq  = data1_i == data2_i;
    assign is_lt  = $signed(data1_i) < $signed(data2_i);
    assign is_ltu = data1_i < data2_i;

    always_comb begin
        unique case (cmp_op_i)
            cmp_beq:  taken_o = is_eq;
            cmp_bne:  taken_o = !is_eq;
            cmp_blt:  taken_o = is_lt;
            cmp_bge:  taken_o = !is_lt;
            cmp_bltu: taken_o = is_ltu;
            cmp_bgeu: taken_o = !is_ltu;
            default:  taken_o = 1'b0;  // Unused encodings never branch.
        endcase
    end

endmodule

//--- ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
    input  ex_pkg::data_t     pc_i,
    input  ex_pkg::data_t     rs1_data_i,
    input  ex_pkg::data_t     rs2_data_i,
    input  ex_pkg::data_t     imm_i,
    input  ex_pkg::data_t     mem_fwd_data_i,
    input  ex_pkg::data_t     wb_fwd_data_i,
    input  ex_pkg::fwd_sel_t  rs1_sel_i,
    input  ex_pkg::fwd_sel_t  rs2_sel_i,
    input  ex_pkg::src1_sel_t src1_sel_i,
    input  ex_pkg::src2_sel_t src2_sel_i,
    input  ex_pkg::alu_op_t   alu_op_i,
    input  ex_pkg::cmp_op_t   cmp_op_i,
    input  logic              valid_i,
    input  logic              is_branch_i,
    input  logic              is_jump_i,
    output ex_pkg::data_t     result_o,
    output ex_pkg::data_t     redirect_pc_o,
    output logic              redirect_o
);

    import ex_pkg::*;

    data_t rs1_data;
    data_t rs2_data;
    data_t src1_data;
    data_t src2_data;
    data_t alu_result;
    logic  taken;

    always_comb begin
        unique case (rs1_sel_i)
            id2ex_buf:   rs1_data = rs1_data_i;
            mem_forward: rs1_data = mem_fwd_data_i;
            wb_forward:  rs1_data = wb_fwd_data_i;
            default:     rs1_data = '0;
        endcase
        unique case (rs2_sel_i)
            id2ex_buf:   rs2_data = rs2_data_i;
            mem_forward: rs2_data = mem_fwd_data_i;
            wb_forward:  rs2_data = wb_fwd_data_i;
            default:     rs2_data = '0;
        endcase
    end

    assign src1_data = (src1_sel_i == src1_pc)  ? pc_i  : rs1_data;
    assign src2_data = (src2_sel_i == src2_imm) ? imm_i : rs2_data;

    alu alu_i (
        .alu_op_i    (alu_op_i),
        .data1_i     (src1_data),
        .data2_i     (src2_data),
        .alu_result_o(alu_result)
    );

    branch_cmp branch_cmp_i (
        .cmp_op_i(cmp_op_i),
        .data1_i (rs1_data),  // The comparator always sees the register operands.
        .data2_i (rs2_data),
        .taken_o (taken)
    );

    assign result_o      = is_jump_i ? pc_i + data_t'(INSTR_BYTES) : alu_result;
    assign redirect_pc_o = pc_i + imm_i;
    assign redirect_o    = valid_i && (is_jump_i || (is_branch_i && taken));

endmodule

//--- ex_pipe_top.sv
`timescale 1ns/1ps

module ex_pipe_top (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              stall_i,
    input  logic              valid_i,
    input  ex_pkg::data_t     pc_i,
    input  ex_pkg::reg_addr_t rs1_addr_i,
    input  ex_pkg::reg_addr_t rs2_addr_i,
    input  ex_pkg::reg_addr_t rd_addr_i,
    input  ex_pkg::data_t     rs1_data_i,
    input  ex_pkg::data_t     rs2_data_i,
    input  ex_pkg::data_t     imm_i,
    input  ex_pkg::alu_op_t   alu_op_i,
    input  ex_pkg::src1_sel_t src1_sel_i,
    input  ex_pkg::src2_sel_t src2_sel_i,
    input  ex_pkg::cmp_op_t   cmp_op_i,
    input  logic              is_branch_i,
    input  logic              is_jump_i,
    input  logic              wb_en_i,
    input  ex_pkg::reg_addr_t wb_rd_addr_i,
    input  logic              wb_fwd_en_i,
    input  ex_pkg::data_t     wb_data_i,
    output logic              valid_o,
    output ex_pkg::reg_addr_t rd_addr_o,
    output ex_pkg::data_t     result_o,
    output logic              wb_en_o,
    output logic              redirect_o,
    output ex_pkg::data_t     redirect_pc_o
);

    import ex_pkg::*;

    id_ex_t   id_ex_d;
    id_ex_t   id_ex_q;
    ex_mem_t  ex_mem_d;
    ex_mem_t  ex_mem_q;
    fwd_sel_t rs1_sel;
    fwd_sel_t rs2_sel;
    data_t    ex_result;
    data_t    ex_redirect_pc;
    logic     ex_redirect;
    logic     mem_wr;

    assign id_ex_d = '{valid: valid_i, pc: pc_i, rs1_addr: rs1_addr_i, rs2_addr: rs2_addr_i,
                       rd_addr: rd_addr_i, rs1_data: rs1_data_i, rs2_data: rs2_data_i,
                       imm: imm_i, alu_op: alu_op_i, src1_sel: src1_sel_i,
                       src2_sel: src2_sel_i, cmp_op: cmp_op_i, is_branch: is_branch_i,
                       is_jump: is_jump_i, wb_en: wb_en_i};

    // The instruction behind a redirect is on the wrong path and becomes a bubble.
    pipe_reg #(.payload_t(id_ex_t)) id_ex_reg_i (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .hold_i  (stall_i),
        .flush_i (ex_redirect && !stall_i),
        .d_i     (id_ex_d),
        .q_o     (id_ex_q)
    );

    assign mem_wr = ex_mem_q.valid && ex_mem_q.wb_en;

    fwd_unit fwd_unit_i (
        .rs1_addr_i   (id_ex_q.rs1_addr),
        .rs2_addr_i   (id_ex_q.rs2_addr),
        .mem_rd_addr_i(ex_mem_q.rd_addr),
        .mem_wr_i     (mem_wr),
        .wb_rd_addr_i (wb_rd_addr_i),
        .wb_en_i      (wb_fwd_en_i),
        .rs1_sel_o    (rs1_sel),
        .rs2_sel_o    (rs2_sel)
    );

    ex_stage ex_stage_i (
        .pc_i          (id_ex_q.pc),
        .rs1_data_i    (id_ex_q.rs1_data),
        .rs2_data_i    (id_ex_q.rs2_data),
        .imm_i         (id_ex_q.imm),
        .mem_fwd_data_i(ex_mem_q.result),
        .wb_fwd_data_i (wb_data_i),
        .rs1_sel_i     (rs1_sel),
        .rs2_sel_i     (rs2_sel),
        .src1_sel_i    (id_ex_q.src1_sel),
        .src2_sel_i    (id_ex_q.src2_sel),
        .alu_op_i      (id_ex_q.alu_op),
        .cmp_op_i      (id_ex_q.cmp_op),
        .valid_i       (id_ex_q.valid),
        .is_branch_i   (id_ex_q.is_branch),
        .is_jump_i     (id_ex_q.is_jump),
        .result_o      (ex_result),
        .redirect_pc_o (ex_redirect_pc),
        .redirect_o    (ex_redirect)
    );

    // Write enable only counts for a live instruction.
    assign ex_mem_d = '{valid: id_ex_q.valid, rd_addr: id_ex_q.rd_addr, result: ex_result,
                        wb_en: id_ex_q.valid && id_ex_q.wb_en, redirect: ex_redirect,
                        redirect_pc: ex_redirect_pc};

    pipe_reg #(.payload_t(ex_mem_t)) ex_mem_reg_i (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .hold_i  (stall_i),
        .flush_i (1'b0),
        .d_i     (ex_mem_d),
        .q_o     (ex_mem_q)
    );

    assign valid_o       = ex_mem_q.valid;
    assign rd_addr_o     = ex_mem_q.rd_addr;
    assign result_o      = ex_mem_q.result;
    assign wb_en_o       = ex_mem_q.wb_en;
    assign redirect_o    = ex_mem_q.redirect;
    assign redirect_pc_o = ex_mem_q.redirect_pc;

endmodule

//--- ex_pipe_sva.sv
`timescale 1ns/1ps

module ex_pipe_sva (
    input logic              clk_i,
    input logic              arst_n_i,
    input logic              stall_i,
    input logic              valid_o,
    input ex_pkg::reg_addr_t rd_addr_o,
    input ex_pkg::data_t     result_o,
    input logic              wb_en_o,
    input logic              redirect_o,
    input ex_pkg::data_t     redirect_pc_o
);

    redirect_has_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        redirect_o |-> valid_o)
        else $error("redirect_o is high while valid_o is low");

    // A stalled edge leaves EX/MEM untouched.
    stall_freezes_outputs: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        stall_i |=> $stable({valid_o, rd_addr_o, result_o, wb_en_o, redirect_o,
                             redirect_pc_o}))
        else $error("EX/MEM outputs changed across a stalled cycle");

    reset_clears_valid: assert property (@(posedge clk_i) $rose(arst_n_i) |-> !valid_o)
        else $error("valid_o is high right after reset");

endmodule

//--- tb_ex_pipe.sv
`timescale 1ns/1ps

module tb_ex_pipe;

    import ex_pkg::*;

    logic      clk_i, arst_n_i, stall_i, valid_i;
    logic      is_branch_i, is_jump_i, wb_en_i, wb_fwd_en_i;
    data_t     pc_i, rs1_data_i, rs2_data_i, imm_i, wb_data_i;
    reg_addr_t rs1_addr_i, rs2_addr_i, rd_addr_i, wb_rd_addr_i;
    alu_op_t   alu_op_i;
    src1_sel_t src1_sel_i;
    src2_sel_t src2_sel_i;
    cmp_op_t   cmp_op_i;
    logic      valid_o, wb_en_o, redirect_o;
    reg_addr_t rd_addr_o;
    data_t     result_o, redirect_pc_o;

    id_ex_t      m_idex;  // Model copies of both pipeline registers.
    ex_mem_t     m_exmem;
    logic [15:0] lfsr;
    bit          k_hazard, k_branch, k_stall, k_narrow, timed_out;
    int          errors, checks, tests;

    ex_pipe_top ex_pipe_top_i (.*);

    bind ex_pipe_top ex_pipe_sva ex_pipe_sva_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // Taps 16, 14, 13, 11.
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic data_t rand_word();
        logic [2:0] b;
        if (k_narrow) begin
            b = 3'(take_bits(3));
            return {{29{b[2]}}, b};  // Small signed values make equal compares common.
        end
        return take_bits(32);
    endfunction

    function automatic data_t model_alu(input alu_op_t op, input data_t a, input data_t b);
        data_t      r;
        logic [4:0] sh;
        logic       ltu;
        sh  = b[4:0];
        ltu = a < b;
        case (op)
            alu_add:   r = a + b;
            alu_sub:   r = a - b;
            alu_sll:   r = a << sh;
            alu_slt:   r = ((a[31] != b[31]) ? a[31] : ltu) ? 32'd1 : 32'd0;
            alu_sltu:  r = ltu ? 32'd1 : 32'd0;
            alu_xor:   r = a ^ b;
            alu_srl:   r = a >> sh;
            alu_sra:   r = (a >> sh) | (a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'd0);
            alu_or:    r = a | b;
            alu_and:   r = a & b;
            alu_pass2: r = b;
            default:   r = '0;
        endcase
        return r;
    endfunction

    function automatic logic model_taken(input cmp_op_t op, input data_t a, input data_t b);
        logic ltu;
        logic lt;
        ltu = a < b;
        lt  = (a[31] != b[31]) ? a[31] : ltu;  // Differing signs decide the signed order.
        case (op)
            cmp_beq:  return a == b;
            cmp_bne:  return a != b;
            cmp_blt:  return lt;
            cmp_bge:  return !lt;
            cmp_bltu: return ltu;
            cmp_bgeu: return !ltu;
            default:  return 1'b0;
        endcase
    endfunction

    function automatic data_t fwd_value(input reg_addr_t a, input data_t own);
        if (a != '0 && m_exmem.wb_en && m_exmem.rd_addr == a) begin
            return m_exmem.result;
        end
        if (a != '0 && wb_fwd_en_i && wb_rd_addr_i == a) begin
            return wb_data_i;
        end
        return own;
    endfunction

    task automatic model_step();
        data_t r1, r2, s1, s2, res;
        logic  redir;
        r1    = fwd_value(m_idex.rs1_addr, m_idex.rs1_data);
        r2    = fwd_value(m_idex.rs2_addr, m_idex.rs2_data);
        s1    = (m_idex.src1_sel == src1_pc) ? m_idex.pc : r1;
        s2    = (m_idex.src2_sel == src2_imm) ? m_idex.imm : r2;
        res   = m_idex.is_jump ? m_idex.pc + 32'd4 : model_alu(m_idex.alu_op, s1, s2);
        redir = m_idex.valid && (m_idex.is_jump ||
                (m_idex.is_branch && model_taken(m_idex.cmp_op, r1, r2)));
        if (!stall_i) begin
            m_exmem = '{valid: m_idex.valid, rd_addr: m_idex.rd_addr, result: res,
                        wb_en: m_idex.valid && m_idex.wb_en, redirect: redir,
                        redirect_pc: m_idex.pc + m_idex.imm};
            if (redir) begin
                m_idex = '0;  // The younger instruction is squashed.
            end else begin
                m_idex = '{valid: valid_i, pc: pc_i, rs1_addr: rs1_addr_i,
                           rs2_addr: rs2_addr_i, rd_addr: rd_addr_i, rs1_data: rs1_data_i,
                           rs2_data: rs2_data_i, imm: imm_i, alu_op: alu_op_i,
                           src1_sel: src1_sel_i, src2_sel: src2_sel_i, cmp_op: cmp_op_i,
                           is_branch: is_branch_i, is_jump: is_jump_i, wb_en: wb_en_i};
            end
        end
    endtask

    task automatic check_field(input string name, input data_t exp, input data_t act);
        checks++;
        assert (act === exp) else begin
            $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_outputs();
        check_field("valid_o", data_t'(m_exmem.valid), data_t'(valid_o));
        check_field("rd_addr_o", data_t'(m_exmem.rd_addr), data_t'(rd_addr_o));
        check_field("result_o", m_exmem.result, result_o);
        check_field("wb_en_o", data_t'(m_exmem.wb_en), data_t'(wb_en_o));
        check_field("redirect_o", data_t'(m_exmem.redirect), data_t'(redirect_o));
        check_field("redirect_pc_o", m_exmem.redirect_pc, redirect_pc_o);
    endtask

    // Mode 0 is random, mode 1 a bubble and mode 2 a plain valid instruction.
    task automatic drive_inputs(input int mode);
        valid_i      = (take_bits(2) != 0);
        pc_i         = data_t'(take_bits(14) << 2);
        rs1_addr_i   = reg_addr_t'(take_bits(2));
        rs2_addr_i   = reg_addr_t'(take_bits(2));
        rd_addr_i    = reg_addr_t'(take_bits(2));
        rs1_data_i   = rand_word();
        rs2_data_i   = rand_word();
        imm_i        = rand_word();
        alu_op_i     = alu_op_t'(4'(take_bits(4) % 11));
        src1_sel_i   = src1_sel_t'(1'(take_bits(1)));
        src2_sel_i   = src2_sel_t'(1'(take_bits(1)));
        cmp_op_i     = cmp_op_t'(3'(take_bits(3) % 6));
        is_branch_i  = k_branch && (take_bits(1) != 0);
        is_jump_i    = k_branch && (take_bits(3) == 0);
        wb_en_i      = k_hazard && (take_bits(2) != 0);
        wb_rd_addr_i = reg_addr_t'(take_bits(2));
        wb_fwd_en_i  = k_hazard && (take_bits(1) != 0);
        wb_data_i    = rand_word();
        stall_i      = k_stall && (take_bits(2) == 0);
        if (mode != 0) begin
            valid_i = (mode == 2);
            stall_i = 1'b0;
        end
        if (mode == 2) begin
            is_branch_i = 1'b0;
            is_jump_i   = 1'b0;
        end
    endtask

    task automatic cycle(input int mode);
        @(negedge clk_i);
        compare_outputs();
        drive_inputs(mode);
        model_step();
    endtask

    task automatic wait_valid();
        int n;
        n = 0;
        repeat (2) cycle(1);
        cycle(2);
        while (valid_o !== 1'b1 && n < 10) begin
            cycle(1);
            n++;
        end
        if (valid_o !== 1'b1) begin
            $display("Timeout: valid_o never rose for the last instruction of the phase.");
            timed_out = 1'b1;
        end
    endtask

    task automatic run_phase(input string name, input int mode, input int n_cycles,
                             input bit hazard, input bit branch, input bit stall,
                             input bit narrow);
        int errors_before;
        if (!timed_out) begin
            errors_before = errors;
            k_hazard      = hazard;
            k_branch      = branch;
            k_stall       = stall;
            k_narrow      = narrow;
            repeat (n_cycles) cycle(mode);
            wait_valid();
            tests++;
            $display("Phase %s finished with %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        lfsr      = 16'd48660;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        timed_out = 1'b0;
        arst_n_i  = 1'b0;
        drive_inputs(1);
        m_idex  = '0;
        m_exmem = '0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;
        model_step();
        run_phase("reset", 1, 6, 1'b1, 1'b1, 1'b0, 1'b0);
        run_phase("alu", 0, 300, 1'b0, 1'b0, 1'b0, 1'b0);
        run_phase("forwarding", 0, 300, 1'b1, 1'b0, 1'b0, 1'b0);
        run_phase("branch", 0, 300, 1'b1, 1'b1, 1'b0, 1'b1);
        run_phase("stall", 0, 400, 1'b1, 1'b1, 1'b1, 1'b0);
        $display("%0d tests, %0d checks, %0d errors, timeout %0d", tests, checks, errors,
                 timed_out);
        if (errors == 0 && !timed_out) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
ex_pkg.sv
pipe_reg.sv
fwd_unit.sv
alu.sv
branch_cmp.sv
ex_stage.sv
ex_pipe_top.sv
ex_pipe_sva.sv
tb_ex_pipe.sv

//--- Makefile
TOP = tb_ex_pipe

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f list.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f list.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "SOME TESTS FAILED" sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
